// ==== common/rv_types_pkg.sv ====
// Shared RV32I decode types: widths, opcode and ALU enums,
// word constants and the IF/ID and ID/EX payload structs
`default_nettype none

package rv_types_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int XLEN      = 32;
  localparam int REG_SEL_W = 5;
  localparam int NUM_REGS  = 32;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_SEL_W-1:0] reg_sel_t;

  // Word constants used as default operands
  localparam word_t ZERO = 32'h0000_0000;
  localparam word_t FOUR = 32'h0000_0004;

  // ==============================
  // Encodings
  // ==============================
  // Major opcode, instruction bits [6:2]
  typedef enum logic [4:0] {
    INSTR_LOAD  = 5'b00000,
    INSTR_OPIMM = 5'b00100,
    INSTR_AUIPC = 5'b00101,
    INSTR_STORE = 5'b01000,
    INSTR_OP    = 5'b01100,
    INSTR_LUI   = 5'b01101,
    INSTR_BR    = 5'b11000,
    INSTR_JALR  = 5'b11001,
    INSTR_JAL   = 5'b11011,
    INSTR_SYS   = 5'b11100
  } opcode_t;

  // ALU operation as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } aluop_t;

  // ==============================
  // Pipeline payloads
  // ==============================
  typedef struct packed {
    word_t pc;
    word_t ir;
  } pipe_ifid_t;

  typedef struct packed {
    word_t  pc;
    word_t  ir;
    aluop_t aluop;
    logic   regwr_alu;
    word_t  op1;
    word_t  op2;
    word_t  addr;
    logic   jump;
    logic   branch;
  } pipe_idex_t;

endpackage

`default_nettype wire

// ==== decode/branch_compare.sv ====
// Branch condition evaluation for the six RV32I branch types
`timescale 1ns/1ps
`default_nettype none

module branch_compare
  import rv_types_pkg::*;
(
  input  wire logic [2:0] op,
  input  wire word_t      rs1,
  input  wire word_t      rs2,
  output logic            branch
);

  // Condition picked by funct3
  always_comb begin
    case (op)
      // BEQ / BNE
      3'd0: branch = (rs1 == rs2);
      3'd1: branch = (rs1 != rs2);
      // BLT / BGE, two's complement
      3'd4: branch = ($signed(rs1) < $signed(rs2));
      3'd5: branch = ($signed(rs1) >= $signed(rs2));
      // BLTU / BGEU
      3'd6: branch = (rs1 < rs2);
      3'd7: branch = (rs1 >= rs2);
      // Reserved encodings never take
      default: branch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== decode/id_stage.sv ====
// ID stage: operation decode, address generation, branch evaluation
// and the registered ID/EX payload with valid/ready and flush
`timescale 1ns/1ps
`default_nettype none

module id_stage
  import rv_types_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rstz,
  input  wire logic       flush,
  // IF/ID
  input  wire pipe_ifid_t fetch,
  input  wire word_t      immediate,
  input  wire word_t      regrd_rs1,
  input  wire word_t      regrd_rs2,
  input  wire logic       fetch_vld,
  output logic            fetch_rdy,
  // ID/EX
  output pipe_idex_t      decode,
  output logic            decode_vld,
  input  wire logic       decode_rdy
);

  opcode_t    opcode;
  reg_sel_t   rd;
  logic [2:0] funct3;
  logic [6:0] funct7;

  aluop_t     aluop;
  word_t      op1;
  word_t      op2;
  logic       regwr_alu;

  word_t      base;
  word_t      offset;
  word_t      addr_raw;
  word_t      addr;
  logic       align;

  logic       branch;
  logic       accept;
  pipe_idex_t next_decode;

  // ==============================
  // Instruction fields
  // ==============================
  assign opcode = opcode_t'(fetch.ir[6:2]);
  assign rd     = fetch.ir[11:7];
  assign funct3 = fetch.ir[14:12];
  assign funct7 = fetch.ir[31:25];

  // ALU result goes to rd, never for x0
  assign regwr_alu = (rd != '0) &&
                     (opcode == INSTR_LUI   || opcode == INSTR_AUIPC ||
                      opcode == INSTR_JAL   || opcode == INSTR_JALR  ||
                      opcode == INSTR_OPIMM || opcode == INSTR_OP);

  // ==============================
  // Operation decoder
  // ==============================
  always_comb begin
    // PC + 4 unless told otherwise, which is the link value for jumps
    aluop  = ADD;
    op1    = fetch.pc;
    op2    = FOUR;
    // Address defaults to the sequential PC
    align  = 1'b0;
    base   = fetch.pc;
    offset = FOUR;

    case (opcode)
      INSTR_LUI: begin
        op1 = ZERO;
        op2 = immediate;
      end
      INSTR_AUIPC: begin
        op2 = immediate;
      end
      INSTR_JAL: begin
        offset = immediate;
      end
      INSTR_JALR: begin
        align  = 1'b1;
        base   = regrd_rs1;
        offset = immediate;
      end
      INSTR_BR: begin
        offset = immediate;
      end
      INSTR_OPIMM: begin
        // funct7[5] only matters for SRAI vs SRLI; other imm bits are data
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          aluop = aluop_t'({funct7[5], funct3});
        end else begin
          aluop = aluop_t'({1'b0, funct3});
        end
        op1 = regrd_rs1;
        op2 = immediate;
      end
      INSTR_OP: begin
        aluop = aluop_t'({funct7[5], funct3});
        op1   = regrd_rs1;
        op2   = regrd_rs2;
      end
      default: begin
      end
    endcase
  end

  // ==============================
  // Address generation
  // ==============================
  assign addr_raw = base + offset;
  // JALR target has bit 0 forced low
  assign addr = {addr_raw[31:1], addr_raw[0] & ~align};

  branch_compare u_branch_compare (
    .op     (funct3),
    .rs1    (regrd_rs1),
    .rs2    (regrd_rs2),
    .branch (branch)
  );

  // ==============================
  // ID/EX register
  // ==============================
  assign fetch_rdy = ~decode_vld | decode_rdy;
  assign accept    = fetch_vld & fetch_rdy & ~flush;

  always_comb begin
    next_decode.pc        = fetch.pc;
    next_decode.ir        = fetch.ir;
    next_decode.aluop     = aluop;
    next_decode.regwr_alu = regwr_alu;
    next_decode.op1       = op1;
    next_decode.op2       = op2;
    next_decode.addr      = addr;
    next_decode.jump      = (opcode == INSTR_JAL) || (opcode == INSTR_JALR);
    // Comparator output only counts for real branches
    next_decode.branch    = branch && (opcode == INSTR_BR);
  end

  // Valid flag, flush wins
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      decode_vld <= 1'b0;
    end else if (flush) begin
      decode_vld <= 1'b0;
    end else if (accept) begin
      decode_vld <= 1'b1;
    end else if (decode_vld && decode_rdy) begin
      decode_vld <= 1'b0;
    end
  end

  // Payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      decode <= next_decode;
    end
  end

  // Stalled output must not change under the consumer
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rstz)
    (decode_vld && !decode_rdy) |=> $stable(decode)
  );

  // Empty output stage always takes a new item
  a_rdy_when_empty : assert property (
    @(posedge clk) disable iff (!rstz)
    !decode_vld |-> fetch_rdy
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_decode_top \
  -Mdir obj_dir -o sim_decode > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

// ==== source/decode_top.sv ====
// Decode stage top: register file, immediate generator and ID stage
`timescale 1ns/1ps
`default_nettype none

module decode_top
  import rv_types_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rstz,
  input  wire logic       flush,
  // IF/ID side
  input  wire pipe_ifid_t fetch,
  input  wire logic       fetch_vld,
  output logic            fetch_rdy,
  // ID/EX side
  output pipe_idex_t      decode,
  output logic            decode_vld,
  input  wire logic       decode_rdy,
  // Register write port
  input  wire word_t      regwr_data,
  input  wire reg_sel_t   regwr_sel,
  input  wire logic       regwr_en
);

  reg_sel_t rs1_sel;
  reg_sel_t rs2_sel;
  word_t    regrd_rs1;
  word_t    regrd_rs2;
  word_t    immediate;

  // Source register fields straight off the fetched word
  assign rs1_sel = fetch.ir[19:15];
  assign rs2_sel = fetch.ir[24:20];

  regfile u_regfile (
    .clk      (clk),
    .rstz     (rstz),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (regrd_rs1),
    .rs2_data (regrd_rs2),
    .wr_sel   (regwr_sel),
    .wr_data  (regwr_data),
    .wr_en    (regwr_en)
  );

  imm_gen u_imm_gen (
    .ir  (fetch.ir),
    .imm (immediate)
  );

  id_stage u_id_stage (
    .clk        (clk),
    .rstz       (rstz),
    .flush      (flush),
    .fetch      (fetch),
    .immediate  (immediate),
    .regrd_rs1  (regrd_rs1),
    .regrd_rs2  (regrd_rs2),
    .fetch_vld  (fetch_vld),
    .fetch_rdy  (fetch_rdy),
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy)
  );

endmodule

`default_nettype wire

// ==== source/imm_gen.sv ====
// Immediate extraction with sign extension for I, S, B, U and J formats
`timescale 1ns/1ps
`default_nettype none

module imm_gen
  import rv_types_pkg::*;
(
  input  wire word_t ir,
  output word_t      imm
);

  opcode_t opcode;

  assign opcode = opcode_t'(ir[6:2]);

  always_comb begin
    case (opcode)
      // I-type
      INSTR_JALR, INSTR_LOAD, INSTR_OPIMM:
        imm = {{20{ir[31]}}, ir[31:20]};
      // S-type, offset split around rs2
      INSTR_STORE:
        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      // B-type, halfword aligned
      INSTR_BR:
        imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      // U-type, upper 20 bits
      INSTR_LUI, INSTR_AUIPC:
        imm = {ir[31:12], 12'h000};
      // J-type
      INSTR_JAL:
        imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      // No immediate for anything else
      default:
        imm = ZERO;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
// 32 x 32-bit integer register file, two async reads, one sync write
`timescale 1ns/1ps
`default_nettype none

module regfile
  import rv_types_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rstz,
  input  wire reg_sel_t rs1_sel,
  input  wire reg_sel_t rs2_sel,
  output word_t         rs1_data,
  output word_t         rs2_data,
  input  wire reg_sel_t wr_sel,
  input  wire word_t    wr_data,
  input  wire logic     wr_en
);

  // x0 has a slot too, the write guard keeps it at zero
  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= ZERO;
      end
    end else if (wr_en && (wr_sel != '0)) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Reads see the array directly, so a write shows up next cycle
  assign rs1_data = regs[rs1_sel];
  assign rs2_data = regs[rs2_sel];

  // x0 reads back zero
  a_x0_zero : assert property (
    @(posedge clk) disable iff (!rstz)
    (rs1_sel == '0) |-> (rs1_data == ZERO)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
common/rv_types_pkg.sv
decode/branch_compare.sv
decode/id_stage.sv
source/imm_gen.sv
source/regfile.sv
source/decode_top.sv
tb/tb_decode_top.sv

// ==== tb/tb_decode_top.sv ====
// Testbench for decode_top: reference model, random stimulus,
// payload and handshake assertions, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top
  import rv_types_pkg::*;
();

  localparam int SEED       = 50424;
  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int N_RST      = 8;
  localparam int N_ALU      = 200;
  localparam int N_JMP      = 80;
  localparam int N_BP       = 160;
  localparam int N_FLUSH    = 3;
  // Item count incl. register writes, 20 cycles each plus margin
  localparam int ITEMS       = N_RST + N_ALU + N_JMP + 48 + N_BP + 2 * N_FLUSH + 64;
  localparam int WATCHDOG_NS = (ITEMS * 20 + 200) * CLK_PERIOD;

  logic       clk = 1'b0;
  logic       rstz;
  logic       flush;
  pipe_ifid_t fetch;
  logic       fetch_vld;
  logic       fetch_rdy;
  pipe_idex_t decode;
  logic       decode_vld;
  logic       decode_rdy;
  word_t      regwr_data;
  reg_sel_t   regwr_sel;
  logic       regwr_en;

  // Reference state
  word_t      shadow [NUM_REGS];
  pipe_idex_t exp_q [$];
  pipe_idex_t exp_head;
  logic       exp_ok = 1'b0;
  logic       acc_d;
  word_t      pc_next;
  int         bp_pct;
  int         err_cnt = 0;
  int         n_tests = 0;
  int         n_failed = 0;
  int         n_checked = 0;

  decode_top dut0 (
    .clk(clk), .rstz(rstz), .flush(flush),
    .fetch(fetch), .fetch_vld(fetch_vld), .fetch_rdy(fetch_rdy),
    .decode(decode), .decode_vld(decode_vld), .decode_rdy(decode_rdy),
    .regwr_data(regwr_data), .regwr_sel(regwr_sel), .regwr_en(regwr_en)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // Reference model
  // ==============================
  function automatic pipe_idex_t predict(input word_t pc, input word_t ir);
    pipe_idex_t p;
    opcode_t    opc;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      sx;
    word_t      imm;
    opc = opcode_t'(ir[6:2]);
    f3  = ir[14:12];
    a   = (ir[19:15] == '0) ? ZERO : shadow[ir[19:15]];
    b   = (ir[24:20] == '0) ? ZERO : shadow[ir[24:20]];
    imm = ZERO;
    // Immediates from arithmetic shifts of the whole word
    case (opc)
      INSTR_OPIMM, INSTR_JALR: imm = word_t'($signed(ir) >>> 20);
      INSTR_LUI, INSTR_AUIPC: imm = ir & 32'hffff_f000;
      INSTR_BR: begin
        sx  = word_t'($signed(ir) >>> 19);
        imm = {sx[31:12], ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      INSTR_JAL: begin
        sx  = word_t'($signed(ir) >>> 11);
        imm = {sx[31:20], ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      default: imm = ZERO;
    endcase
    p.pc = pc;
    p.ir = ir;
    p.aluop = ADD;
    p.op1 = pc;
    p.op2 = FOUR;
    p.addr = pc + FOUR;
    p.jump = (opc == INSTR_JAL) || (opc == INSTR_JALR);
    p.branch = 1'b0;
    p.regwr_alu = (ir[11:7] != '0) &&
                  (opc inside {INSTR_LUI, INSTR_AUIPC, INSTR_JAL, INSTR_JALR,
                               INSTR_OPIMM, INSTR_OP});
    case (opc)
      INSTR_LUI: begin
        p.op1 = ZERO;
        p.op2 = imm;
      end
      INSTR_AUIPC: p.op2 = imm;
      INSTR_JAL: p.addr = pc + imm;
      INSTR_JALR: p.addr = (a + imm) & ~word_t'(1);
      INSTR_BR: begin
        p.addr = pc + imm;
        case (f3)
          3'd0: p.branch = (a == b);
          3'd1: p.branch = (a != b);
          3'd4: p.branch = ($signed(a) < $signed(b));
          3'd5: p.branch = !($signed(a) < $signed(b));
          3'd6: p.branch = (a < b);
          3'd7: p.branch = !(a < b);
          default: p.branch = 1'b0;
        endcase
      end
      INSTR_OPIMM: begin
        // Bit 30 selects arithmetic shift only
        p.aluop = aluop_t'({(f3 == 3'd1 || f3 == 3'd5) & ir[30], f3});
        p.op1 = a;
        p.op2 = imm;
      end
      INSTR_OP: begin
        p.aluop = aluop_t'({ir[30], f3});
        p.op1 = a;
        p.op2 = b;
      end
      default: begin
      end
    endcase
    return p;
  endfunction

  // Expected queue follows the handshake seen just before each edge
  always @(posedge clk) begin
    acc_d <= rstz && !flush && fetch_vld && fetch_rdy;
    if (rstz && decode_vld && decode_rdy) n_checked++;
    if (rstz && flush) begin
      exp_q.delete();
    end else if (rstz) begin
      if (decode_vld && decode_rdy && exp_q.size() > 0) void'(exp_q.pop_front());
      if (fetch_vld && fetch_rdy) exp_q.push_back(predict(fetch.pc, fetch.ir));
    end
    // After the prediction, so an item accepted here sees the old value
    if (regwr_en && regwr_sel != '0) shadow[regwr_sel] = regwr_data;
  end

  // Head is settled half a cycle ahead of the checking edge
  always @(negedge clk) begin
    exp_ok = exp_q.size() > 0;
    if (exp_ok) exp_head = exp_q[0];
  end

  // ==============================
  // Checking assertions
  // ==============================
  task automatic show(input string name, input word_t got, input word_t exp);
    $display("MISMATCH decode.%s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  endtask

  task automatic report_mismatch(input pipe_idex_t got, input pipe_idex_t exp);
    if (got.pc != exp.pc) show("pc", got.pc, exp.pc);
    if (got.ir != exp.ir) show("ir", got.ir, exp.ir);
    if (got.aluop != exp.aluop) show("aluop", word_t'(got.aluop), word_t'(exp.aluop));
    if (got.regwr_alu != exp.regwr_alu)
      show("regwr_alu", word_t'(got.regwr_alu), word_t'(exp.regwr_alu));
    if (got.op1 != exp.op1) show("op1", got.op1, exp.op1);
    if (got.op2 != exp.op2) show("op2", got.op2, exp.op2);
    if (got.addr != exp.addr) show("addr", got.addr, exp.addr);
    if (got.jump != exp.jump) show("jump", word_t'(got.jump), word_t'(exp.jump));
    if (got.branch != exp.branch) show("branch", word_t'(got.branch), word_t'(exp.branch));
  endtask

  a_handoff_expected : assert property (
    @(posedge clk) disable iff (!rstz) (decode_vld && decode_rdy) |-> exp_ok
  ) else begin
    err_cnt++;
    $display("Item handed off with nothing expected at %0t", $time);
  end

  a_payload : assert property (
    @(posedge clk) disable iff (!rstz)
    (decode_vld && decode_rdy && exp_ok) |-> (decode == exp_head)
  ) else begin
    err_cnt++;
    report_mismatch($sampled(decode), exp_head);
  end

  // Accepted item is valid at the very next edge
  a_one_edge_latency : assert property (
    @(posedge clk) disable iff (!rstz) (fetch_vld && fetch_rdy && !flush) |=> decode_vld
  ) else begin
    err_cnt++;
    $display("decode_vld not high one edge after acceptance at %0t", $time);
  end

  // Empty or draining output takes the next item
  a_rdy_when_free : assert property (
    @(posedge clk) disable iff (!rstz) (!decode_vld || decode_rdy) |-> fetch_rdy
  ) else begin
    err_cnt++;
    $display("fetch_rdy low while output empty or draining at %0t", $time);
  end

  // Full output blocks fetch and holds its payload
  a_stall_blocks : assert property (
    @(posedge clk) disable iff (!rstz) (decode_vld && !decode_rdy) |-> !fetch_rdy
  ) else begin
    err_cnt++;
    $display("fetch_rdy high while output stalled at %0t", $time);
  end

  a_stall_stable : assert property (
    @(posedge clk) disable iff (!rstz) (decode_vld && !decode_rdy) |=> $stable(decode)
  ) else begin
    err_cnt++;
    $display("decode changed while stalled at %0t", $time);
  end

  // ==============================
  // Stimulus helpers
  // ==============================
  function automatic word_t enc(input opcode_t opc, input logic [24:0] up);
    return {up, opc, 2'b11};
  endfunction

  function automatic word_t rand_alu(input bit rd_zero);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    reg_sel_t    rd;
    f3  = 3'($urandom);
    rd  = rd_zero ? reg_sel_t'(0) : reg_sel_t'($urandom);
    imm = 12'($urandom);
    f7  = (f3 == 3'd0 || f3 == 3'd5) ? {1'($urandom), 6'd0} : 7'd0;
    if ($urandom % 2 == 0)
      return enc(INSTR_OP, {f7, reg_sel_t'($urandom), reg_sel_t'($urandom), f3, rd});
    if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
    if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};
    return enc(INSTR_OPIMM, {imm, reg_sel_t'($urandom), f3, rd});
  endfunction

  function automatic word_t rand_jump(input int k);
    logic [24:0] up;
    up = 25'($urandom);
    if (k % 4 == 0) return enc(INSTR_LUI, up);
    if (k % 4 == 1) return enc(INSTR_AUIPC, up);
    if (k % 4 == 2) return enc(INSTR_JAL, up);
    return enc(INSTR_JALR, {up[24:8], 3'b000, up[4:0]});
  endfunction

  function automatic word_t br_instr(input logic [2:0] f3, input reg_sel_t a, input reg_sel_t b);
    logic [24:0] up;
    up = 25'($urandom);
    return enc(INSTR_BR, {up[24:18], b, a, f3, up[4:0]});
  endfunction

  // Present one item and wait until it is taken
  task automatic issue(input word_t ir);
    fetch.pc  = pc_next;
    fetch.ir  = ir;
    fetch_vld = 1'b1;
    do begin
      decode_rdy = int'($urandom % 100) >= bp_pct;
      @(negedge clk);
    end while (!acc_d);
    pc_next = pc_next + FOUR;
  endtask

  task automatic write_reg(input reg_sel_t sel, input word_t data);
    fetch_vld  = 1'b0;
    regwr_en   = 1'b1;
    regwr_sel  = sel;
    regwr_data = data;
    @(negedge clk);
    regwr_en = 1'b0;
  endtask

  task automatic drain();
    fetch_vld  = 1'b0;
    decode_rdy = 1'b1;
    while (decode_vld || exp_q.size() > 0) @(negedge clk);
  endtask

  task automatic close_test(input string name, input int e0);
    drain();
    n_tests++;
    if (err_cnt != e0) begin
      n_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - e0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    assert (!decode_vld && fetch_rdy) else begin
      err_cnt++;
      $display("Handshake not idle after reset: decode_vld high or fetch_rdy low");
    end
    // Nothing written yet, so every register reads zero
    for (int i = 0; i < N_RST; i++) issue(rand_alu(1'b0));
    close_test("reset_state", e0);
  endtask

  task automatic test_alu();
    int e0;
    e0 = err_cnt;
    for (int r = 1; r < NUM_REGS; r++) write_reg(reg_sel_t'(r), word_t'($urandom));
    for (int i = 0; i < N_ALU; i++) issue(rand_alu(i % 8 == 0));
    close_test("alu_ops", e0);
  endtask

  task automatic test_jump();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < N_JMP; i++) issue(rand_jump(i));
    close_test("lui_auipc_jumps", e0);
  endtask

  task automatic test_branch();
    int e0;
    e0 = err_cnt;
    // Equal pair, mixed sign, unsigned large
    write_reg(5'd1, 32'd5);
    write_reg(5'd2, 32'd5);
    write_reg(5'd3, 32'hffff_fffd);
    write_reg(5'd4, 32'd7);
    write_reg(5'd5, 32'hf000_0000);
    write_reg(5'd6, 32'd1);
    for (int f = 0; f < 8; f++) begin
      issue(br_instr(3'(f), 5'd1, 5'd2));
      issue(br_instr(3'(f), 5'd3, 5'd4));
      issue(br_instr(3'(f), 5'd4, 5'd3));
      issue(br_instr(3'(f), 5'd5, 5'd6));
      issue(br_instr(3'(f), 5'd6, 5'd5));
      issue(br_instr(3'(f), 5'd3, 5'd5));
    end
    close_test("branches", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int kind;
    e0 = err_cnt;
    bp_pct = 60;
    for (int i = 0; i < N_BP; i++) begin
      kind = int'($urandom % 3);
      if (i % 16 == 15) write_reg(reg_sel_t'($urandom), word_t'($urandom));
      if (kind == 0) issue(rand_alu(1'b0));
      else if (kind == 1) issue(rand_jump(i));
      else issue(br_instr(3'($urandom), reg_sel_t'($urandom), reg_sel_t'($urandom)));
    end
    bp_pct = 0;
    close_test("backpressure", e0);
  endtask

  task automatic test_flush();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < N_FLUSH; i++) begin
      // Park one item, then flush it while another is offered
      bp_pct = 100;
      issue(rand_alu(1'b0));
      decode_rdy = 1'b0;
      flush      = 1'b1;
      fetch.pc   = pc_next;
      fetch.ir   = rand_jump(i);
      fetch_vld  = 1'b1;
      @(negedge clk);
      flush     = 1'b0;
      fetch_vld = 1'b0;
      assert (!decode_vld) else begin
        err_cnt++;
        $display("decode_vld still high after flush at %0t", $time);
      end
      bp_pct = 0;
      issue(rand_alu(1'b0));
      drain();
    end
    close_test("flush", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    rstz       = 1'b0;
    flush      = 1'b0;
    fetch      = '0;
    fetch_vld  = 1'b0;
    decode_rdy = 1'b0;
    regwr_en   = 1'b0;
    regwr_sel  = '0;
    regwr_data = '0;
    bp_pct     = 0;
    pc_next    = word_t'($urandom) & ~word_t'(3);
    for (int r = 0; r < NUM_REGS; r++) shadow[r] = ZERO;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstz = 1'b1;
    test_reset();
    test_alu();
    test_jump();
    test_branch();
    test_backpressure();
    test_flush();
    $display("tests %0d, failed %0d, errors %0d, items checked %0d",
             n_tests, n_failed, err_cnt, n_checked);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
